//--- hdl/periph_bus_pkg.sv
////////////////////////////////////////
// Peripheral bus definitions.
// Widths and vector types of the host
// request bus and the device address map.
////////////////////////////////////////

package periph_bus_pkg;

  // Bus widths.
  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;
  localparam int unsigned ByteWidth     = 8;
  localparam int unsigned RegAddrWidth  = 8;

  // Device indices into the one-hot select.
  localparam int unsigned NrDevices = 2;
  localparam int unsigned GpioIdx   = 0;
  localparam int unsigned TimerIdx  = 1;

  typedef logic [BusAddrWidth-1:0]  bus_addr_t;
  typedef logic [BusDataWidth-1:0]  bus_data_t;
  typedef logic [BusByteEnable-1:0] bus_be_t;
  typedef logic [RegAddrWidth-1:0]  reg_addr_t;
  typedef logic [NrDevices-1:0]     dev_sel_t;

  ////////////////////////////////////////
  // Address map.
  ////////////////////////////////////////

  localparam bus_addr_t GpioBase      = 32'h8000_0000;
  localparam bus_addr_t TimerBase     = 32'h8004_0000;
  localparam bus_addr_t DevWindowMask = 32'h0000_FFFF;

  // Replace the enabled bytes of a register word.
  function automatic bus_data_t be_merge(input bus_data_t old_val,
                                         input bus_data_t new_val,
                                         input bus_be_t   be);
    bus_data_t merged;
    merged = old_val;
    for (int i = 0; i < BusByteEnable; i++) begin
      if (be[i]) begin
        merged[i*ByteWidth +: ByteWidth] = new_val[i*ByteWidth +: ByteWidth];
      end
    end
    return merged;
  endfunction

endpackage

//--- hdl/periph_regs_pkg.sv
////////////////////////////////////////
// Peripheral register definitions.
// Offsets, widths and reset values of
// the GPIO and timer registers.
////////////////////////////////////////

package periph_regs_pkg;

  // GPIO pin widths.
  localparam int unsigned GpiWidth = 13;
  localparam int unsigned GpoWidth = 24;

  // Machine timer width.
  localparam int unsigned TimerWidth = 64;

  typedef logic [GpiWidth-1:0]   gpi_t;
  typedef logic [GpoWidth-1:0]   gpo_t;
  typedef logic [TimerWidth-1:0] timer_val_t;

  // GPIO register offsets.
  localparam periph_bus_pkg::reg_addr_t GpioOutOffset = 8'h00;
  localparam periph_bus_pkg::reg_addr_t GpioInOffset  = 8'h04;

  // Timer register offsets, low half first.
  localparam periph_bus_pkg::reg_addr_t MtimeLowOffset     = 8'h00;
  localparam periph_bus_pkg::reg_addr_t MtimeHighOffset    = 8'h04;
  localparam periph_bus_pkg::reg_addr_t MtimecmpLowOffset  = 8'h08;
  localparam periph_bus_pkg::reg_addr_t MtimecmpHighOffset = 8'h0C;

  // Compare starts out of reach so no interrupt fires.
  localparam timer_val_t MtimecmpReset = '1;

endpackage

//--- hdl/bus_fabric.sv
////////////////////////////////////////
// Bus fabric.
// Decodes host requests to the GPIO or
// timer and merges their responses.
// Unmapped requests get an error.
////////////////////////////////////////

module bus_fabric
  import periph_bus_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,

  // Host side.
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_be_t   bus_be_i,
  input  bus_addr_t bus_addr_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o,

  // Device side.
  output dev_sel_t  dev_req_o,
  output logic      dev_we_o,
  output bus_be_t   dev_be_o,
  output reg_addr_t dev_offset_o,
  output bus_data_t dev_wdata_o,
  input  logic      gpio_rvalid_i,
  input  bus_data_t gpio_rdata_i,
  input  logic      timer_rvalid_i,
  input  bus_data_t timer_rdata_i
);

  dev_sel_t dev_sel;
  dev_sel_t sel_q;
  logic     unmapped_q;

  ////////////////////////////////////////
  // Request decode.
  ////////////////////////////////////////

  // Compare the address bits above the window.
  assign dev_sel[GpioIdx]  = (bus_addr_i & ~DevWindowMask) == GpioBase;
  assign dev_sel[TimerIdx] = (bus_addr_i & ~DevWindowMask) == TimerBase;

  assign dev_req_o    = bus_req_i ? dev_sel : '0;
  assign dev_we_o     = bus_we_i;
  assign dev_be_o     = bus_be_i;
  assign dev_offset_o = bus_addr_i[RegAddrWidth-1:0];
  assign dev_wdata_o  = bus_wdata_i;

  // Remember where each request went.
  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      sel_q      <= '0;
      unmapped_q <= 1'b0;
    end else begin
      sel_q      <= dev_req_o;
      unmapped_q <= bus_req_i & ~(|dev_sel);
    end
  end

  ////////////////////////////////////////
  // Response merge.
  ////////////////////////////////////////

  always_comb begin
    bus_rvalid_o = unmapped_q;
    bus_rdata_o  = '0;
    if (sel_q[GpioIdx]) begin
      bus_rvalid_o = gpio_rvalid_i;
      bus_rdata_o  = gpio_rdata_i;
    end else if (sel_q[TimerIdx]) begin
      bus_rvalid_o = timer_rvalid_i;
      bus_rdata_o  = timer_rdata_i;
    end
  end

  // Only an unmapped address errors.
  assign bus_err_o = unmapped_q;

endmodule

//--- hdl/gpio.sv
////////////////////////////////////////
// GPIO block.
// Byte-writable output register and a
// synchronised, readable input register.
////////////////////////////////////////

module gpio
  import periph_bus_pkg::*;
  import periph_regs_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,

  // Device bus.
  input  logic      dev_req_i,
  input  logic      dev_we_i,
  input  bus_be_t   dev_be_i,
  input  reg_addr_t dev_offset_i,
  input  bus_data_t dev_wdata_i,
  output logic      dev_rvalid_o,
  output bus_data_t dev_rdata_o,

  // Pins.
  input  gpi_t      gp_i,
  output gpo_t      gp_o
);

  gpo_t      gpo_q;
  gpi_t      gpi_meta_q;
  gpi_t      gpi_q;
  bus_data_t gpo_merged;
  bus_data_t rdata_d;
  logic      gpo_wr;

  ////////////////////////////////////////
  // Output register.
  ////////////////////////////////////////

  assign gpo_wr     = dev_req_i & dev_we_i & (dev_offset_i == GpioOutOffset);
  assign gpo_merged = be_merge(bus_data_t'(gpo_q), dev_wdata_i, dev_be_i);

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      gpo_q <= '0;
    end else if (gpo_wr) begin
      // Upper byte has no pins behind it.
      gpo_q <= gpo_merged[GpoWidth-1:0];
    end
  end

  assign gp_o = gpo_q;

  // Two-stage input synchroniser.
  always_ff @(posedge clk_sys_i) begin
    gpi_meta_q <= gp_i;
    gpi_q      <= gpi_meta_q;
  end

  ////////////////////////////////////////
  // Read response.
  ////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    if (!dev_we_i) begin
      case (dev_offset_i)
        GpioOutOffset: rdata_d = bus_data_t'(gpo_q);
        GpioInOffset:  rdata_d = bus_data_t'(gpi_q);
        default:       rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      dev_rvalid_o <= 1'b0;
    end else begin
      dev_rvalid_o <= dev_req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    dev_rdata_o <= rdata_d;
  end

endmodule

//--- hdl/timer.sv
////////////////////////////////////////
// Machine timer.
// Free-running 64-bit mtime, a compare
// register and a registered interrupt.
////////////////////////////////////////

module timer
  import periph_bus_pkg::*;
  import periph_regs_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,

  // Device bus.
  input  logic      dev_req_i,
  input  logic      dev_we_i,
  input  bus_be_t   dev_be_i,
  input  reg_addr_t dev_offset_i,
  input  bus_data_t dev_wdata_i,
  output logic      dev_rvalid_o,
  output bus_data_t dev_rdata_o,

  // Interrupt.
  output logic      timer_irq_o
);

  timer_val_t mtime_q;
  timer_val_t mtime_d;
  timer_val_t mtimecmp_q;
  timer_val_t mtimecmp_d;
  bus_data_t  rdata_d;
  logic       wr;

  assign wr = dev_req_i & dev_we_i;

  ////////////////////////////////////////
  // Register updates.
  ////////////////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + 1'b1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (dev_offset_i)
        // A write to mtime replaces this cycle's increment.
        MtimeLowOffset: begin
          mtime_d = {mtime_q[TimerWidth-1:BusDataWidth],
                     be_merge(mtime_q[BusDataWidth-1:0], dev_wdata_i, dev_be_i)};
        end
        MtimeHighOffset: begin
          mtime_d = {be_merge(mtime_q[TimerWidth-1:BusDataWidth], dev_wdata_i, dev_be_i),
                     mtime_q[BusDataWidth-1:0]};
        end
        MtimecmpLowOffset: begin
          mtimecmp_d = {mtimecmp_q[TimerWidth-1:BusDataWidth],
                        be_merge(mtimecmp_q[BusDataWidth-1:0], dev_wdata_i, dev_be_i)};
        end
        MtimecmpHighOffset: begin
          mtimecmp_d = {be_merge(mtimecmp_q[TimerWidth-1:BusDataWidth], dev_wdata_i,
                                 dev_be_i),
                        mtimecmp_q[BusDataWidth-1:0]};
        end
        default: begin
          mtimecmp_d = mtimecmp_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= MtimecmpReset;
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      // Level interrupt, one cycle behind the compare.
      timer_irq_o <= mtime_q >= mtimecmp_q;
    end
  end

  ////////////////////////////////////////
  // Read response.
  ////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    if (!dev_we_i) begin
      case (dev_offset_i)
        MtimeLowOffset:     rdata_d = mtime_q[BusDataWidth-1:0];
        MtimeHighOffset:    rdata_d = mtime_q[TimerWidth-1:BusDataWidth];
        MtimecmpLowOffset:  rdata_d = mtimecmp_q[BusDataWidth-1:0];
        MtimecmpHighOffset: rdata_d = mtimecmp_q[TimerWidth-1:BusDataWidth];
        default:            rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (reset_i) begin
      dev_rvalid_o <= 1'b0;
    end else begin
      dev_rvalid_o <= dev_req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    dev_rdata_o <= rdata_d;
  end

endmodule

//--- hdl/periph_system.sv
////////////////////////////////////////
// Peripheral subsystem top level.
// Bus fabric with a GPIO block and a
// machine timer behind it.
////////////////////////////////////////

module periph_system
  import periph_bus_pkg::*;
  import periph_regs_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      reset_i,

  // Host bus.
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_be_t   bus_be_i,
  input  bus_addr_t bus_addr_i,
  input  bus_data_t bus_wdata_i,
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o,

  // Pins and interrupt.
  input  gpi_t      gp_i,
  output gpo_t      gp_o,
  output logic      timer_irq_o
);

  // Shared device request lines.
  dev_sel_t  dev_req;
  logic      dev_we;
  bus_be_t   dev_be;
  reg_addr_t dev_offset;
  bus_data_t dev_wdata;

  // Per-device responses.
  logic      gpio_rvalid;
  bus_data_t gpio_rdata;
  logic      timer_rvalid;
  bus_data_t timer_rdata;

  bus_fabric u_bus_fabric (
    .clk_sys_i     (clk_sys_i),
    .reset_i       (reset_i),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_be_i      (bus_be_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .bus_err_o     (bus_err_o),
    .dev_req_o     (dev_req),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_offset_o  (dev_offset),
    .dev_wdata_o   (dev_wdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata)
  );

  gpio u_gpio (
    .clk_sys_i   (clk_sys_i),
    .reset_i     (reset_i),
    .dev_req_i   (dev_req[GpioIdx]),
    .dev_we_i    (dev_we),
    .dev_be_i    (dev_be),
    .dev_offset_i(dev_offset),
    .dev_wdata_i (dev_wdata),
    .dev_rvalid_o(gpio_rvalid),
    .dev_rdata_o (gpio_rdata),
    .gp_i        (gp_i),
    .gp_o        (gp_o)
  );

  timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .reset_i     (reset_i),
    .dev_req_i   (dev_req[TimerIdx]),
    .dev_we_i    (dev_we),
    .dev_be_i    (dev_be),
    .dev_offset_i(dev_offset),
    .dev_wdata_i (dev_wdata),
    .dev_rvalid_o(timer_rvalid),
    .dev_rdata_o (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- testbench/tb_bus_tasks.svh
////////////////////////////////////////
// Testbench bus helpers.
// Host read and write tasks, random
// numbers and the result counters.
////////////////////////////////////////

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam logic [31:0] LfsrSeed        = 32'habee;
localparam logic [31:0] LfsrTaps        = 32'h8020_0003;
localparam int unsigned ResponseTimeout = 4;

logic [31:0] lfsr_state   = LfsrSeed;
int unsigned errors       = 0;
int unsigned tests_passed = 0;
int unsigned tests_failed = 0;

// One Galois step, returns the bit shifted out.
function automatic logic lfsr_step();
  logic out_bit;
  out_bit    = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ LfsrTaps;
  end
  return out_bit;
endfunction

function automatic logic [31:0] rand_bits(input int unsigned nbits);
  logic [31:0] val;
  val = '0;
  for (int unsigned i = 0; i < nbits; i++) begin
    val = {val[30:0], lfsr_step()};
  end
  return val;
endfunction

task automatic report_mismatch(input string name, input bus_data_t expected,
                               input bus_data_t actual);
  errors++;
  $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
endtask

// Drops the request and waits for its response.
task automatic await_response(output bus_data_t rdata, output logic err);
  int unsigned waited;
  rdata = '0;
  err   = 1'b0;
  @(posedge clk_sys_i);
  bus_req_i <= 1'b0;
  bus_we_i  <= 1'b0;
  @(posedge clk_sys_i);
  waited = 1;
  while (!bus_rvalid_o && waited < ResponseTimeout) begin
    @(posedge clk_sys_i);
    waited++;
  end
  if (bus_rvalid_o) begin
    rdata = bus_rdata_o;
    err   = bus_err_o;
  end else begin
    errors++;
    $display("No bus response within %0d cycles", ResponseTimeout);
  end
endtask

task automatic write_reg(input bus_addr_t addr, input bus_data_t data, input bus_be_t be);
  bus_data_t rdata;
  logic      err;
  @(posedge clk_sys_i);
  bus_req_i   <= 1'b1;
  bus_we_i    <= 1'b1;
  bus_be_i    <= be;
  bus_addr_i  <= addr;
  bus_wdata_i <= data;
  await_response(rdata, err);
  // Write responses carry no data.
  assert (rdata == '0) else report_mismatch("bus_rdata_o", '0, rdata);
endtask

task automatic read_reg(input bus_addr_t addr, output bus_data_t rdata);
  logic err;
  @(posedge clk_sys_i);
  bus_req_i   <= 1'b1;
  bus_we_i    <= 1'b0;
  bus_be_i    <= '1;
  bus_addr_i  <= addr;
  bus_wdata_i <= '0;
  await_response(rdata, err);
endtask

`endif

//--- testbench/tb_periph_system.sv
////////////////////////////////////////
// Peripheral subsystem testbench.
// Drives the host bus, GPIO pins and
// timer, with assertion based checks.
////////////////////////////////////////

module tb_periph_system
  import periph_bus_pkg::*;
  import periph_regs_pkg::*;
();

  // Rough length of the test sequence in cycles.
  localparam int unsigned TestCycles     = 1000;
  localparam int unsigned WatchdogCycles = 3 * TestCycles;
  localparam int unsigned GpioWrites     = 8;
  localparam int unsigned IrqQuietCycles = 50;
  localparam int unsigned IrqRiseCycles  = 150;
  localparam int unsigned IrqHoldCycles  = 20;
  localparam int unsigned IrqDropCycles  = 3;
  localparam int unsigned BurstLength    = 9;
  localparam bus_addr_t   UnmappedAddr   = 32'h8002_0004;

  logic      clk_sys_i = 1'b0;
  logic      reset_i;
  logic      bus_req_i;
  logic      bus_we_i;
  bus_be_t   bus_be_i;
  bus_addr_t bus_addr_i;
  bus_data_t bus_wdata_i;
  logic      bus_rvalid_o;
  bus_data_t bus_rdata_o;
  logic      bus_err_o;
  gpi_t      gp_i;
  gpo_t      gp_o;
  logic      timer_irq_o;

  // Request seen one cycle earlier.
  logic        req_d1      = 1'b0;
  logic        unmapped_d1 = 1'b0;
  bus_data_t   gpo_model;
  int unsigned errors_at_start;

  `include "tb_bus_tasks.svh"

  always #2 clk_sys_i = ~clk_sys_i;

  periph_system periph_system_inst (
    .clk_sys_i   (clk_sys_i),
    .reset_i     (reset_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_be_i    (bus_be_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o (bus_rdata_o),
    .bus_err_o   (bus_err_o),
    .gp_i        (gp_i),
    .gp_o        (gp_o),
    .timer_irq_o (timer_irq_o)
  );

  function automatic bus_addr_t gpio_addr(input reg_addr_t offset);
    return GpioBase | bus_addr_t'(offset);
  endfunction

  function automatic bus_addr_t timer_addr(input reg_addr_t offset);
    return TimerBase | bus_addr_t'(offset);
  endfunction

  // Outside both device windows.
  function automatic logic is_unmapped(input bus_addr_t addr);
    bus_addr_t base;
    base = addr & ~DevWindowMask;
    return (base != GpioBase) && (base != TimerBase);
  endfunction

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  ////////////////////////////////////////
  // Response protocol checks.
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    req_d1      <= bus_req_i;
    unmapped_d1 <= bus_req_i && is_unmapped(bus_addr_i);
  end

  rvalid_follows_req: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    bus_rvalid_o == req_d1)
    else report_mismatch("bus_rvalid_o", bus_data_t'($sampled(req_d1)),
                         bus_data_t'($sampled(bus_rvalid_o)));

  err_only_unmapped: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    bus_rvalid_o |-> bus_err_o == unmapped_d1)
    else report_mismatch("bus_err_o", bus_data_t'($sampled(unmapped_d1)),
                         bus_data_t'($sampled(bus_err_o)));

  err_has_no_data: assert property (@(posedge clk_sys_i) disable iff (reset_i)
    bus_err_o |-> bus_rdata_o == '0)
    else report_mismatch("bus_rdata_o", '0, $sampled(bus_rdata_o));

  initial begin
    repeat (WatchdogCycles) @(posedge clk_sys_i);
    $display("Watchdog expired after %0d cycles", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////

  initial begin
    bus_data_t   rdata;
    bus_data_t   prev_time;
    bus_data_t   wdata;
    bus_data_t   mask;
    bus_be_t     be;
    gpi_t        gpi_val;
    int unsigned cycles;
    bus_addr_t   burst [BurstLength];
    bus_data_t   burst_rdata [BurstLength];

    reset_i     = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_be_i    = '0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    gp_i        = '0;
    gpo_model   = '0;
    repeat (2) @(posedge clk_sys_i);
    reset_i <= 1'b0;
    @(posedge clk_sys_i);

    start_test();
    assert (gp_o == '0) else report_mismatch("gp_o", '0, bus_data_t'(gp_o));
    assert (!timer_irq_o) else report_mismatch("timer_irq_o", '0, bus_data_t'(timer_irq_o));
    assert (!bus_rvalid_o) else report_mismatch("bus_rvalid_o", '0, bus_data_t'(bus_rvalid_o));
    assert (!bus_err_o) else report_mismatch("bus_err_o", '0, bus_data_t'(bus_err_o));
    finish_test("Reset state");

    start_test();
    for (int unsigned i = 0; i < GpioWrites; i++) begin
      wdata     = rand_bits(BusDataWidth);
      be        = bus_be_t'(rand_bits(BusByteEnable));
      mask      = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      // Only 24 output pins exist.
      gpo_model = ((gpo_model & ~mask) | (wdata & mask)) & 32'h00FF_FFFF;
      write_reg(gpio_addr(GpioOutOffset), wdata, be);
      assert (bus_data_t'(gp_o) == gpo_model)
        else report_mismatch("gp_o", gpo_model, bus_data_t'(gp_o));
      read_reg(gpio_addr(GpioOutOffset), rdata);
      assert (rdata == gpo_model) else report_mismatch("bus_rdata_o", gpo_model, rdata);
    end
    finish_test("GPIO output");

    start_test();
    for (int unsigned i = 0; i < 2; i++) begin
      gpi_val = gpi_t'(rand_bits(GpiWidth));
      @(posedge clk_sys_i);
      gp_i <= gpi_val;
      // The read below is issued on the third edge.
      repeat (2) @(posedge clk_sys_i);
      read_reg(gpio_addr(GpioInOffset), rdata);
      assert (rdata == bus_data_t'(gpi_val))
        else report_mismatch("bus_rdata_o", bus_data_t'(gpi_val), rdata);
    end
    finish_test("GPIO input");

    start_test();
    read_reg(timer_addr(MtimeLowOffset), prev_time);
    read_reg(timer_addr(MtimeLowOffset), rdata);
    assert (rdata > prev_time) else begin
      errors++;
      $display("Error: mtime low 0x%h not above 0x%h", rdata, prev_time);
    end
    wdata = rand_bits(BusDataWidth) & 32'h7FFF_FFFF;
    write_reg(timer_addr(MtimeHighOffset), '0, '1);
    write_reg(timer_addr(MtimeLowOffset), wdata, '1);
    read_reg(timer_addr(MtimeLowOffset), rdata);
    assert (rdata >= wdata && rdata < wdata + 32'd16) else begin
      errors++;
      $display("Error: mtime low 0x%h outside 0x%h to 0x%h", rdata, wdata, wdata + 32'd15);
    end
    finish_test("Timer counting");

    start_test();
    write_reg(timer_addr(MtimeLowOffset), '0, '1);
    write_reg(timer_addr(MtimeHighOffset), '0, '1);
    write_reg(timer_addr(MtimecmpHighOffset), '0, '1);
    write_reg(timer_addr(MtimecmpLowOffset), 32'd100, '1);
    for (cycles = 0; cycles < IrqQuietCycles; cycles++) begin
      @(posedge clk_sys_i);
      assert (!timer_irq_o) else report_mismatch("timer_irq_o", '0, bus_data_t'(timer_irq_o));
    end
    while (!timer_irq_o && cycles < IrqRiseCycles) begin
      @(posedge clk_sys_i);
      cycles++;
    end
    assert (timer_irq_o) else begin
      errors++;
      $display("Timer interrupt did not rise within %0d cycles", IrqRiseCycles);
    end
    repeat (IrqHoldCycles) begin
      @(posedge clk_sys_i);
      assert (timer_irq_o) else report_mismatch("timer_irq_o", 32'd1, bus_data_t'(timer_irq_o));
    end
    write_reg(timer_addr(MtimecmpLowOffset), '1, '1);
    cycles = 0;
    while (timer_irq_o && cycles < IrqDropCycles) begin
      @(posedge clk_sys_i);
      cycles++;
    end
    assert (!timer_irq_o) else begin
      errors++;
      $display("Timer interrupt did not drop within %0d cycles", IrqDropCycles);
    end
    finish_test("Timer interrupt");

    start_test();
    // Nonzero GPIO data so mapped reads differ from error responses.
    gpo_model = 32'h00C3_5A96;
    write_reg(gpio_addr(GpioOutOffset), gpo_model, '1);
    // Rotate over GPIO, timer compare low and an unmapped address.
    for (int unsigned k = 0; k < BurstLength; k++) begin
      case (k % 3)
        0: begin
          burst[k]       = gpio_addr(GpioOutOffset);
          burst_rdata[k] = gpo_model;
        end
        1: begin
          burst[k]       = timer_addr(MtimecmpLowOffset);
          burst_rdata[k] = 32'hFFFF_FFFF;
        end
        default: begin
          burst[k]       = UnmappedAddr;
          burst_rdata[k] = '0;
        end
      endcase
    end
    // One read per cycle, each response checked in the cycle after its request.
    for (int unsigned k = 0; k <= BurstLength; k++) begin
      bus_req_i <= (k < BurstLength);
      if (k < BurstLength) begin
        bus_we_i   <= 1'b0;
        bus_be_i   <= '1;
        bus_addr_i <= burst[k];
      end
      @(posedge clk_sys_i);
      if (k > 0) begin
        assert (bus_rdata_o == burst_rdata[k-1])
          else report_mismatch("bus_rdata_o", burst_rdata[k-1], bus_rdata_o);
      end
    end
    finish_test("Back-to-back requests");

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+testbench
hdl/periph_bus_pkg.sv
hdl/periph_regs_pkg.sv
hdl/bus_fabric.sv
hdl/gpio.sv
hdl/timer.sv
hdl/periph_system.sv
testbench/tb_periph_system.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the peripheral subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_periph_system -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_periph_system)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -Fxq "Test completed successfully"; then
  exit 0
else
  echo "Pass message not found"
  exit 1
fi
